// File: design/sub_bus_pkg.sv
// ----------------------------------------------------------------------
// Sub board bus fabric types
// Bus widths and the request and response words that travel between
// the arbiter, decoder, access and response stages
// ----------------------------------------------------------------------
`default_nettype none

package sub_bus_pkg;

    typedef logic [19:1] bus_addr_t;    // word address, byte bit dropped
    typedef logic [15:0] bus_data_t;
    typedef logic [1:0]  bus_dsn_t;     // {udsn, ldsn}, active low
    typedef logic        master_id_t;

    // owners of the bus
    localparam master_id_t ID_SUB  = 1'b0;
    localparam master_id_t ID_MAIN = 1'b1;

    // one access as issued by a master
    typedef struct packed {
        bus_addr_t  addr;
        logic       wr;       // high for a write
        bus_dsn_t   dsn;
        bus_data_t  wdata;
        master_id_t id;
    } bus_req_s;

    // finished access on its way back to the master
    typedef struct packed {
        bus_data_t  data;
        master_id_t id;
    } bus_rsp_s;

endpackage

`default_nettype wire

// File: design/sub_map_pkg.sv
// ----------------------------------------------------------------------
// Sub board memory map
// Region encoding and the page boundaries on address bits 19:17
// ----------------------------------------------------------------------
`default_nettype none

package sub_map_pkg;

    import sub_bus_pkg::*;

    typedef logic [2:0] map_page_t;     // address bits 19:17

    localparam map_page_t MAP_ROM_END   = 3'd2;  // pages 0..2 are rom
    localparam map_page_t MAP_RAM_BASE  = 3'd3;
    localparam map_page_t MAP_ROAD_BASE = 3'd4;  // bit 16 splits road/sio

    // nothing answers, the bus floats high
    localparam bus_data_t MAP_OPEN_BUS = '1;

    typedef enum logic [2:0] {
        REG_ROM,
        REG_RAM,
        REG_ROAD,   // road ram
        REG_SIO,    // road control
        REG_NONE
    } map_region_e;

    typedef struct packed {
        bus_req_s    req;
        map_region_e region;
    } decoded_req_s;

endpackage

`default_nettype wire

// File: design/bus_master_arb.sv
// ----------------------------------------------------------------------
// Bus master arbiter
// Grants the shared bus to the main or sub CPU port, main first, and
// tracks each master's req/ack handshake from issue to req drop
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_master_arb
    import sub_bus_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       sub_req,
    input  wire bus_req_s   sub_cmd,
    input  wire logic       sub_ack,
    input  wire logic       main_req,
    input  wire bus_req_s   main_cmd,
    input  wire logic       main_ack,
    input  wire logic       busy,        // access stage holds a chip select
    output logic            out_valid,
    output bus_req_s        out_req,
    input  wire logic       rsp_done,
    input  wire master_id_t rsp_id
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,        // issued, ack not yet up
        ST_WAIT_DROP    // acked, waiting for req to go low
    } grant_state_e;

    grant_state_e st [2];       // indexed by master id
    logic [1:0]   req_v;
    logic [1:0]   issue_v;
    logic         dec_pending;  // request still inside the decoder
    logic         can_issue;

    assign req_v = {main_req, sub_req};

    // nothing may be on its way to the access stage
    assign can_issue = !busy && !out_valid && !dec_pending;

    // fixed priority
    assign issue_v[1] = can_issue && (st[1] == ST_IDLE) && main_req;
    assign issue_v[0] = can_issue && (st[0] == ST_IDLE) && sub_req && !issue_v[1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid   <= 1'b0;
            dec_pending <= 1'b0;
            for (int m = 0; m < 2; m++) begin
                st[m] <= ST_IDLE;
            end
        end else begin
            out_valid   <= |issue_v;
            dec_pending <= out_valid;
            for (int m = 0; m < 2; m++) begin
                case (st[m])
                    ST_IDLE: begin
                        if (issue_v[m]) st[m] <= ST_BUSY;
                    end
                    ST_BUSY: begin
                        if (rsp_done && rsp_id == master_id_t'(m)) begin
                            // req may already be down one clock after the ack edge
                            st[m] <= req_v[m] ? ST_WAIT_DROP : ST_IDLE;
                        end
                    end
                    ST_WAIT_DROP: begin
                        if (!req_v[m]) st[m] <= ST_IDLE;
                    end
                    default: st[m] <= ST_IDLE;
                endcase
            end
        end
    end

    // owner id comes from the grant, not from the master
    always_ff @(posedge clk) begin
        if (issue_v[1]) begin
            out_req    <= main_cmd;
            out_req.id <= ID_MAIN;
        end else if (issue_v[0]) begin
            out_req    <= sub_cmd;
            out_req.id <= ID_SUB;
        end
    end

    // an ack edge must belong to an access this arbiter issued
    a_sub_ack_granted: assert property (@(posedge clk) disable iff (rst)
        $rose(sub_ack) |-> $past(sub_req) && st[0] == ST_BUSY);

    a_main_ack_granted: assert property (@(posedge clk) disable iff (rst)
        $rose(main_ack) |-> $past(main_req) && st[1] == ST_BUSY);

    a_acks_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(sub_ack && main_ack));

endmodule

`default_nettype wire

// File: design/addr_decoder.sv
// ----------------------------------------------------------------------
// Address decoder
// Registers a granted request and tags it with its memory-map region
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module addr_decoder
    import sub_bus_pkg::*, sub_map_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_valid,
    input  wire bus_req_s in_req,
    output logic          out_valid,
    output decoded_req_s  out_dec
);

    map_page_t   page;
    map_region_e region;

    assign page = in_req.addr[19:17];

    always_comb begin
        if (page <= MAP_ROM_END) begin
            region = REG_ROM;
        end else if (page == MAP_RAM_BASE) begin
            region = REG_RAM;
        end else if (page == MAP_ROAD_BASE) begin
            // road ram below, road control above
            region = in_req.addr[16] ? REG_SIO : REG_ROAD;
        end else begin
            region = REG_NONE;  // open bus
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_dec.req    <= in_req;
            out_dec.region <= region;
            if (region == REG_ROM) begin
                out_dec.req.wr <= 1'b0;     // rom write turns into a plain read
            end
        end
    end

endmodule

`default_nettype wire

// File: design/mem_access.sv
// ----------------------------------------------------------------------
// Memory access stage
// Holds one decoded request, raises its chip select and waits for the
// port's ok flag before handing the read data on
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import sub_bus_pkg::*, sub_map_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         in_valid,
    input  wire decoded_req_s in_dec,
    output logic              busy,
    // rom
    output logic              rom_cs,
    input  wire logic         rom_ok,
    input  wire bus_data_t    rom_data,
    // work ram
    output logic              ram_cs,
    input  wire logic         ram_ok,
    input  wire bus_data_t    ram_data,
    // road ram and road control share one port
    output logic              road_cs,
    output logic              sio_cs,
    input  wire logic         road_ok,
    input  wire bus_data_t    road_data,
    // shared bus
    output bus_addr_t         addr,
    output bus_dsn_t          dsn,
    output logic              rnw,
    output bus_data_t         wdata,
    output logic              done,
    output bus_rsp_s          rsp
);

    decoded_req_s cur;
    logic         accept;
    logic         sel_ok;
    bus_data_t    sel_data;

    assign accept = in_valid && !busy;

    always_comb begin
        case (cur.region)
            REG_ROM: begin
                sel_ok   = rom_ok;
                sel_data = rom_data;
            end
            REG_RAM: begin
                sel_ok   = ram_ok;
                sel_data = ram_data;
            end
            REG_ROAD, REG_SIO: begin
                sel_ok   = road_ok;
                sel_data = road_data;
            end
            default: begin
                sel_ok   = 1'b0;
                sel_data = MAP_OPEN_BUS;
            end
        endcase
    end

    assign addr  = cur.req.addr;
    assign dsn   = cur.req.dsn;
    assign rnw   = !cur.req.wr;
    assign wdata = cur.req.wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            rom_cs  <= 1'b0;
            ram_cs  <= 1'b0;
            road_cs <= 1'b0;
            sio_cs  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                if (sel_ok) begin   // selects stay up until the port answers
                    busy    <= 1'b0;
                    done    <= 1'b1;
                    rom_cs  <= 1'b0;
                    ram_cs  <= 1'b0;
                    road_cs <= 1'b0;
                    sio_cs  <= 1'b0;
                end
            end else if (in_valid) begin
                if (in_dec.region == REG_NONE) begin
                    done <= 1'b1;   // nothing to wait for
                end else begin
                    busy    <= 1'b1;
                    rom_cs  <= in_dec.region == REG_ROM;
                    ram_cs  <= in_dec.region == REG_RAM;
                    road_cs <= in_dec.region == REG_ROAD;
                    sio_cs  <= in_dec.region == REG_SIO;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cur      <= in_dec;
            rsp.id   <= in_dec.req.id;
            rsp.data <= MAP_OPEN_BUS;   // kept only for unmapped reads
        end else if (busy && sel_ok) begin
            rsp.data <= sel_data;
        end
    end

    a_one_cs: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, road_cs, sio_cs}));

    // arbiter must hold off while an access is running
    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> !busy);

endmodule

`default_nettype wire

// File: design/bus_response.sv
// ----------------------------------------------------------------------
// Bus response stage
// Keeps each master's finished read and raises its ack no sooner than
// MIN_CYCLES clocks after req rose, in the way of a DTACK generator
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_response
    import sub_bus_pkg::*;
#(
    parameter int MIN_CYCLES = 4
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     in_done,
    input  wire bus_rsp_s in_rsp,
    input  wire logic     sub_req,
    input  wire logic     main_req,
    output bus_data_t     rdata,
    output logic          sub_ack,
    output logic          main_ack,
    output logic          rsp_done,   // one pulse per ack rise
    output master_id_t    rsp_id
);

    localparam int CW = $clog2(MIN_CYCLES + 1);

    logic [CW-1:0] cnt [2];     // clocks since req rose, saturating
    bus_data_t     hold [2];
    logic [1:0]    req_v;
    logic [1:0]    ack_q;
    logic [1:0]    pend;        // response parked until its slot opens
    logic [1:0]    arrive;
    logic [1:0]    ready;
    logic [1:0]    raise;

    assign req_v    = {main_req, sub_req};
    assign sub_ack  = ack_q[0];
    assign main_ack = ack_q[1];

    always_comb begin
        for (int m = 0; m < 2; m++) begin
            arrive[m] = in_done && (in_rsp.id == master_id_t'(m));
            ready[m]  = req_v[m] && (int'(cnt[m]) >= MIN_CYCLES - 1);
        end
        // only one ack up at a time, main wins a tie
        raise[1] = (pend[1] || arrive[1]) && ready[1] && !(|ack_q);
        raise[0] = (pend[0] || arrive[0]) && ready[0] && !(|ack_q) && !raise[1];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack_q    <= '0;
            pend     <= '0;
            rsp_done <= 1'b0;
            rsp_id   <= ID_SUB;
            for (int m = 0; m < 2; m++) begin
                cnt[m] <= '0;
            end
        end else begin
            rsp_done <= |raise;
            rsp_id   <= raise[1] ? ID_MAIN : ID_SUB;
            for (int m = 0; m < 2; m++) begin
                if (!req_v[m]) begin
                    cnt[m] <= '0;
                end else if (cnt[m] != CW'(MIN_CYCLES)) begin
                    cnt[m] <= cnt[m] + 1'b1;
                end
                if (raise[m]) begin
                    ack_q[m] <= 1'b1;
                    pend[m]  <= 1'b0;
                end else begin
                    if (arrive[m]) pend[m] <= 1'b1;
                    if (ack_q[m] && !req_v[m]) ack_q[m] <= 1'b0;  // master let go
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int m = 0; m < 2; m++) begin
            if (arrive[m]) hold[m] <= in_rsp.data;
        end
        if (raise[1]) begin
            rdata <= arrive[1] ? in_rsp.data : hold[1];
        end else if (raise[0]) begin
            rdata <= arrive[0] ? in_rsp.data : hold[0];
        end
    end

endmodule

`default_nettype wire

// File: design/sub_bus_top.sv
// ----------------------------------------------------------------------
// Sub CPU board bus fabric
// Arbiter, decoder, access and response stages between the two CPU
// ports and the rom, work ram and road memory ports
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sub_bus_top
    import sub_bus_pkg::*, sub_map_pkg::*;
#(
    parameter int MIN_CYCLES = 4    // shortest bus cycle in clocks
) (
    input  wire logic      clk,
    input  wire logic      rst,
    // sub cpu
    input  wire logic      sub_req,
    input  wire bus_req_s  sub_cmd,
    output logic           sub_ack,
    // main cpu taking over the bus
    input  wire logic      main_req,
    input  wire bus_req_s  main_cmd,
    output logic           main_ack,
    output bus_data_t      rdata,
    // memories
    output logic           rom_cs,
    input  wire logic      rom_ok,
    input  wire bus_data_t rom_data,
    output logic           ram_cs,
    input  wire logic      ram_ok,
    input  wire bus_data_t ram_data,
    output logic           road_cs,
    output logic           sio_cs,
    input  wire logic      road_ok,
    input  wire bus_data_t road_data,
    output bus_addr_t      addr,
    output bus_dsn_t       dsn,
    output logic           rnw,
    output bus_data_t      wdata
);

    logic         arb_valid;
    bus_req_s     arb_req;
    logic         dec_valid;
    decoded_req_s dec_req;
    logic         acc_busy;
    logic         acc_done;
    bus_rsp_s     acc_rsp;
    logic         rsp_done;
    master_id_t   rsp_id;

    bus_master_arb u_arb (
        .clk(clk), .rst(rst),
        .sub_req(sub_req), .sub_cmd(sub_cmd), .sub_ack(sub_ack),
        .main_req(main_req), .main_cmd(main_cmd), .main_ack(main_ack),
        .busy(acc_busy), .out_valid(arb_valid), .out_req(arb_req),
        .rsp_done(rsp_done), .rsp_id(rsp_id)
    );

    addr_decoder u_dec (
        .clk(clk), .rst(rst),
        .in_valid(arb_valid), .in_req(arb_req),
        .out_valid(dec_valid), .out_dec(dec_req)
    );

    mem_access u_acc (
        .clk(clk), .rst(rst),
        .in_valid(dec_valid), .in_dec(dec_req), .busy(acc_busy),
        .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_data(rom_data),
        .ram_cs(ram_cs), .ram_ok(ram_ok), .ram_data(ram_data),
        .road_cs(road_cs), .sio_cs(sio_cs), .road_ok(road_ok), .road_data(road_data),
        .addr(addr), .dsn(dsn), .rnw(rnw), .wdata(wdata),
        .done(acc_done), .rsp(acc_rsp)
    );

    bus_response #(.MIN_CYCLES(MIN_CYCLES)) u_rsp (
        .clk(clk), .rst(rst),
        .in_done(acc_done), .in_rsp(acc_rsp),
        .sub_req(sub_req), .main_req(main_req),
        .rdata(rdata), .sub_ack(sub_ack), .main_ack(main_ack),
        .rsp_done(rsp_done), .rsp_id(rsp_id)
    );

endmodule

`default_nettype wire

// File: verif/tb_sub_bus.sv
// ----------------------------------------------------------------------
// Sub board bus fabric testbench
// Directed tests over the rom, work ram and road ports with simple
// memory models that answer after a random number of clocks
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_sub_bus
    import sub_bus_pkg::*;
;

    localparam int MIN_CYCLES = 6;
    localparam int WAIT_LIMIT = 200;    // clocks before a wait gives up

    logic       clk;
    logic       rst;
    logic       sub_req;
    bus_req_s   sub_cmd;
    logic       sub_ack;
    logic       main_req;
    bus_req_s   main_cmd;
    logic       main_ack;
    bus_data_t  rdata;
    logic       rom_cs;
    logic       rom_ok;
    bus_data_t  rom_data;
    logic       ram_cs;
    logic       ram_ok;
    bus_data_t  ram_data;
    logic       road_cs;
    logic       sio_cs;
    logic       road_ok;
    bus_data_t  road_data;
    bus_addr_t  addr;
    bus_dsn_t   dsn;
    logic       rnw;
    bus_data_t  wdata;

    bus_data_t  rom_mem [0:196607];     // pages 0..2
    bus_data_t  ram_mem [0:65535];
    bus_data_t  road_mem [0:65535];     // upper half is road control
    int         max_delay;
    logic [3:0] cs_seen;                // {rom, ram, road, sio}
    int         error_count;

    sub_bus_top #(.MIN_CYCLES(MIN_CYCLES)) u_dut (
        .clk(clk), .rst(rst),
        .sub_req(sub_req), .sub_cmd(sub_cmd), .sub_ack(sub_ack),
        .main_req(main_req), .main_cmd(main_cmd), .main_ack(main_ack),
        .rdata(rdata),
        .rom_cs(rom_cs), .rom_ok(rom_ok), .rom_data(rom_data),
        .ram_cs(ram_cs), .ram_ok(ram_ok), .ram_data(ram_data),
        .road_cs(road_cs), .sio_cs(sio_cs), .road_ok(road_ok), .road_data(road_data),
        .addr(addr), .dsn(dsn), .rnw(rnw), .wdata(wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // preload pattern, every address bit takes part
    function automatic bus_data_t mem_fill(bus_addr_t a);
        return a[16:1] ^ {a[19:17], 13'h0a5};
    endfunction

    function automatic bus_data_t merge_bytes(bus_data_t old, bus_data_t wd, bus_dsn_t strobes);
        bus_data_t result;
        result = old;
        if (!strobes[1]) result[15:8] = wd[15:8];
        if (!strobes[0]) result[7:0] = wd[7:0];
        return result;
    endfunction

    function automatic bus_req_s make_cmd(bus_addr_t a, logic wr, bus_dsn_t strobes,
                                          bus_data_t wd, master_id_t id);
        bus_req_s cmd;
        cmd.addr  = a;
        cmd.wr    = wr;
        cmd.dsn   = strobes;
        cmd.wdata = wd;
        cmd.id    = id;
        return cmd;
    endfunction

    function automatic logic ack_of(logic is_main);
        return is_main ? main_ack : sub_ack;
    endfunction

    task automatic fail_now();
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_eq(string name, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("ERR %s expected %0h actual %0h", name, expected, actual);
            fail_now();
        end
    endtask

    // memory port answers, one access at a time
    task automatic answer_port();
        if (rom_cs) begin
            rom_data = rom_mem[addr[18:1]];
            if (!rnw) rom_mem[addr[18:1]] = merge_bytes(rom_data, wdata, dsn);
            rom_ok = 1'b1;
        end else if (ram_cs) begin
            ram_data = ram_mem[addr[16:1]];
            if (!rnw) ram_mem[addr[16:1]] = merge_bytes(ram_data, wdata, dsn);
            ram_ok = 1'b1;
        end else begin
            road_data = road_mem[addr[16:1]];
            if (!rnw) road_mem[addr[16:1]] = merge_bytes(road_data, wdata, dsn);
            road_ok = 1'b1;
        end
    endtask

    initial begin : mem_models
        int   delay;
        int   waited;
        logic active;
        void'($urandom(32'h95bd533f));
        for (int i = 0; i < 196608; i++) rom_mem[i] = mem_fill(bus_addr_t'(i));
        for (int i = 0; i < 65536; i++) begin
            ram_mem[i]  = mem_fill({3'd3, 16'(i)});
            road_mem[i] = mem_fill({3'd4, 16'(i)});
        end
        {rom_ok, ram_ok, road_ok} = 3'b000;
        {rom_data, ram_data, road_data} = '0;
        active = 1'b0;
        delay  = 0;
        waited = 0;
        forever begin
            @(posedge clk);
            #1;
            if (rom_ok || ram_ok || road_ok) begin
                {rom_ok, ram_ok, road_ok} = 3'b000;    // select dropped on this edge
                active = 1'b0;
            end else if (rom_cs || ram_cs || road_cs || sio_cs) begin
                if (!active) begin
                    active = 1'b1;
                    waited = 0;
                    delay  = (max_delay == 0) ? 0 : int'($urandom % (max_delay + 1));
                end
                if (waited >= delay) answer_port();
                else waited++;
            end
        end
    end

    // mid-cycle monitor
    always @(negedge clk) begin
        if (!rst) begin
            cs_seen = cs_seen | {rom_cs, ram_cs, road_cs, sio_cs};
            check_eq("ack_exclusive", 0, sub_ack && main_ack);
        end
    end

    // one full four-phase access, called and left just after a rising edge
    task automatic run_access(string name, logic is_main, bus_addr_t a, logic wr,
                              bus_dsn_t strobes, bus_data_t wd,
                              output bus_data_t rd, output int lat);
        int n;
        n = 0;
        if (is_main) begin
            main_cmd = make_cmd(a, wr, strobes, wd, ID_MAIN);
            main_req = 1'b1;
        end else begin
            sub_cmd = make_cmd(a, wr, strobes, wd, ID_SUB);
            sub_req = 1'b1;
        end
        while (!ack_of(is_main)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) begin
                $display("%s: ack never rose for address %0h", name, a);
                fail_now();
            end
        end
        lat = n;
        rd  = rdata;
        if (is_main) main_req = 1'b0;
        else sub_req = 1'b0;
        n = 0;
        while (ack_of(is_main)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) begin
                $display("%s: ack stayed high after req fell", name);
                fail_now();
            end
        end
    endtask

    task automatic test_handshake();
        bus_data_t rd;
        int        n;
        check_eq("handshake", 6'b0, {sub_ack, main_ack, rom_cs, ram_cs, road_cs, sio_cs});
        sub_cmd = make_cmd({3'd0, 16'h0040}, 1'b0, 2'b00, 16'h0, ID_SUB);
        sub_req = 1'b1;
        n = 0;
        while (!sub_ack) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) begin
                $display("handshake: sub ack never rose");
                fail_now();
            end
        end
        rd = rdata;
        repeat (3) begin    // ack and data hold while req is up
            @(posedge clk);
            #1;
            check_eq("handshake", 1, sub_ack);
            check_eq("handshake", rd, rdata);
        end
        check_eq("handshake", mem_fill({3'd0, 16'h0040}), rd);
        sub_req = 1'b0;
        @(posedge clk);
        #1;
        check_eq("handshake", 0, sub_ack);
    endtask

    task automatic test_rom_read();
        bus_addr_t a [3];
        bus_data_t rd;
        int        lat;
        a[0] = {3'd0, 16'h0000};
        a[1] = {3'd1, 16'h8001};
        a[2] = {3'd2, 16'hffff};
        for (int i = 0; i < 3; i++) begin
            cs_seen = '0;
            run_access("rom_read", i[0], a[i], 1'b0, 2'b00, 16'h0, rd, lat);
            check_eq("rom_read", mem_fill(a[i]), rd);
            check_eq("rom_read", 4'b1000, cs_seen);
        end
    endtask

    task automatic test_ram_write_read();
        bus_addr_t ram_a;
        bus_addr_t rom_a;
        bus_data_t init_w;
        bus_data_t expect_w;
        bus_data_t rd;
        int        lat;
        ram_a    = {3'd3, 16'h0123};
        rom_a    = {3'd1, 16'h0456};
        init_w   = mem_fill(ram_a);
        expect_w = {init_w[15:8], 8'hef};     // low byte only
        run_access("ram_write", 1'b0, ram_a, 1'b1, 2'b10, 16'hbeef, rd, lat);
        run_access("ram_read", 1'b1, ram_a, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("ram_write_read", expect_w, rd);
        expect_w = {8'h12, expect_w[7:0]};
        run_access("ram_write", 1'b1, ram_a, 1'b1, 2'b01, 16'h1200, rd, lat);
        run_access("ram_read", 1'b0, ram_a, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("ram_write_read", expect_w, rd);
        // rom write acked but dropped
        run_access("rom_write", 1'b0, rom_a, 1'b1, 2'b00, 16'hdead, rd, lat);
        run_access("rom_read", 1'b0, rom_a, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("rom_write_dropped", mem_fill(rom_a), rd);
    endtask

    task automatic test_road_sio();
        bus_addr_t road_a;
        bus_addr_t sio_a;
        bus_data_t rd;
        int        lat;
        road_a = {3'd4, 1'b0, 15'h0042};
        sio_a  = {3'd4, 1'b1, 15'h0042};
        cs_seen = '0;
        run_access("road", 1'b0, road_a, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("road", mem_fill(road_a), rd);
        check_eq("road", 4'b0010, cs_seen);
        cs_seen = '0;
        run_access("sio", 1'b1, sio_a, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("sio", mem_fill(sio_a), rd);
        check_eq("sio", 4'b0001, cs_seen);
        cs_seen = '0;
        run_access("unmapped", 1'b0, {3'd5, 16'h0010}, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("unmapped", 16'hffff, rd);
        run_access("unmapped", 1'b1, {3'd7, 16'hffff}, 1'b0, 2'b00, 16'h0, rd, lat);
        check_eq("unmapped", 16'hffff, rd);
        check_eq("unmapped", 4'b0000, cs_seen);
    endtask

    task automatic test_min_cycle();
        bus_addr_t a [4];
        bus_data_t rd;
        int        lat;
        a[0] = {3'd0, 16'h0100};
        a[1] = {3'd3, 16'h0200};
        a[2] = {3'd4, 16'h0300};
        a[3] = {3'd6, 16'h0400};   // unmapped finishes at once
        max_delay = 0;
        for (int i = 0; i < 4; i++) begin
            run_access("min_cycle", i[1], a[i], 1'b0, 2'b00, 16'h0, rd, lat);
            // zero-delay pipeline is shorter than the floor, so ack sits on it
            check_eq("min_cycle", MIN_CYCLES, lat);
        end
        max_delay = 3;
    endtask

    task automatic test_arbitration();
        bus_addr_t rom_a;
        bus_addr_t ram_a;
        bus_data_t main_rd;
        bus_data_t sub_rd;
        logic      main_done;
        logic      sub_done;
        int        first;
        int        n;
        rom_a     = {3'd2, 16'h1234};
        ram_a     = {3'd3, 16'h4321};
        main_cmd  = make_cmd(rom_a, 1'b0, 2'b00, 16'h0, ID_MAIN);
        sub_cmd   = make_cmd(ram_a, 1'b0, 2'b00, 16'h0, ID_SUB);
        main_req  = 1'b1;
        sub_req   = 1'b1;
        main_done = 1'b0;
        sub_done  = 1'b0;
        main_rd   = '0;
        sub_rd    = '0;
        first     = -1;
        n         = 0;
        while (!(main_done && sub_done && !main_ack && !sub_ack)) begin
            @(posedge clk);
            #1;
            n++;
            if (n > WAIT_LIMIT) begin
                $display("arbitration: both masters did not complete");
                fail_now();
            end
            check_eq("arbitration", 0, main_ack && sub_ack);
            if (main_ack && main_req) begin
                main_rd  = rdata;
                main_req = 1'b0;
                main_done = 1'b1;
                if (first < 0) first = 1;
            end
            if (sub_ack && sub_req) begin
                sub_rd   = rdata;
                sub_req  = 1'b0;
                sub_done = 1'b1;
                if (first < 0) first = 0;
            end
        end
        check_eq("arbitration", 1, first);      // main takes the bus first
        check_eq("arbitration", mem_fill(rom_a), main_rd);
        check_eq("arbitration", mem_fill(ram_a), sub_rd);
    endtask

    initial begin
        rst         = 1'b1;
        sub_req     = 1'b0;
        main_req    = 1'b0;
        sub_cmd     = '0;
        main_cmd    = '0;
        max_delay   = 3;
        cs_seen     = '0;
        error_count = 0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        test_handshake();
        test_rom_read();
        test_ram_write_read();
        test_road_sio();
        test_min_cycle();
        test_arbitration();
        if (error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            fail_now();
        end
    end

endmodule

`default_nettype wire

// File: compile.f
design/sub_bus_pkg.sv
design/sub_map_pkg.sv
design/bus_master_arb.sv
design/addr_decoder.sv
design/mem_access.sv
design/bus_response.sv
design/sub_bus_top.sv
verif/tb_sub_bus.sv

// File: Bender.yml
package:
  name: sub_bus_fabric

sources:
  - design/sub_bus_pkg.sv
  - design/sub_map_pkg.sv
  - design/bus_master_arb.sv
  - design/addr_decoder.sv
  - design/mem_access.sv
  - design/bus_response.sv
  - design/sub_bus_top.sv
  - target: test
    files:
      - verif/tb_sub_bus.sv
